// File: mips_pipeline.f
source/mips_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/reg_file.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/mips_pipeline.sv
tests/wb_checker.sv
tests/mips_pipeline_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f mips_pipeline.f \
   --top-module mips_pipeline_tb -o sim_mips

./obj_dir/sim_mips | tee sim.log

if grep -q "Done: no errors" sim.log; then
   exit 0
fi
exit 1

// File: tests/program_input.txt
# I word | D word_addr data | W word_addr data test_name | L led_value
I 20010005
I 2002000C
I 00221820
I AC030000
I 00412022
I 00822824
I 00A13025
I 00C4382A
I AC040004
I AC050008
I AC06000C
I AC070010
I 8C080040
I 21090003
I AC090014
I 10220002
I 20630001
I AC030018
I 10000002
I AC01001C
I AC02001C
I 200301A5
I AC030020
I 1000FFFF
D 10 00000100
W 0000 00000011 add_fwd
W 0001 00000007 sub_fwd
W 0002 00000004 and_chain
W 0003 00000005 or_chain
W 0004 00000001 slt_result
W 0005 00000103 load_use
W 0006 00000012 beq_not_taken
W 0008 000001A5 beq_taken
L A5

// File: tests/mips_pipeline_tb.sv
// MIPS core testbench
module mips_pipeline_tb;

   localparam int DATA_ADDR_W = 16;
   localparam int IMEM_ADDR_W = 10;

   logic clk;
   logic rst_n;
   logic [31:0] instr;
   logic [IMEM_ADDR_W-1:0] imem_addr;
   logic wb_cyc;
   logic wb_stb;
   logic wb_we;
   logic [DATA_ADDR_W-1:0] wb_adr;
   logic [31:0] wb_dat_w;
   logic wb_ack;
   logic [31:0] wb_dat_r;
   logic [7:0] led;
   logic chk_done;
   int chk_errors;

   logic [31:0] rom [0:1023];
   logic [31:0] dmem [0:255];
   logic [15:0] lfsr;
   logic busy;
   logic [1:0] wait_left;
   int prog_words;
   int exp_writes;
   int cycles;
   int limit;
   logic load_ok;

   mips_pipeline #(
      .DATA_ADDR_W(DATA_ADDR_W),
      .IMEM_ADDR_W(IMEM_ADDR_W)
   ) mips_pipeline_i (
      .clk(clk), .rst_n(rst_n), .instr_i(instr), .imem_addr_o(imem_addr),
      .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
      .wb_dat_o(wb_dat_w), .wb_ack_i(wb_ack), .wb_dat_i(wb_dat_r), .led_o(led)
   );

   wb_checker #(
      .ADR_W(DATA_ADDR_W)
   ) wb_checker_i (
      .clk(clk), .rst_n(rst_n), .cyc_i(wb_cyc), .stb_i(wb_stb), .we_i(wb_we),
      .ack_i(wb_ack), .adr_i(wb_adr), .dat_i(wb_dat_w), .led_i(led),
      .done_o(chk_done), .errors_o(chk_errors)
   );

   always #4 clk = ~clk;

   // instruction rom answers in the same cycle
   assign instr = rom[imem_addr];

   // galois lfsr, taps 16,14,13,11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 16'hb400;
      end
      return s >> 1;
   endfunction

   task automatic pick_delay(output logic [1:0] d);
      d[0] = lfsr[0];
      lfsr = lfsr_next(lfsr);
      d[1] = lfsr[0];
      lfsr = lfsr_next(lfsr);
   endtask

   // wishbone slave memory, 0 to 3 wait states
   always @(negedge clk) begin
      if (!rst_n) begin
         wb_ack <= 1'b0;
         busy = 1'b0;
      end else if (wb_ack) begin
         wb_ack <= 1'b0;
         busy = 1'b0;
      end else if (wb_cyc && wb_stb) begin
         if (!busy) begin
            busy = 1'b1;
            pick_delay(wait_left);
         end
         if (wait_left == 2'd0) begin
            wb_ack <= 1'b1;
            if (wb_we) begin
               dmem[wb_adr[7:0]] = wb_dat_w;
            end else begin
               wb_dat_r <= dmem[wb_adr[7:0]];
            end
         end else begin
            wait_left = wait_left - 2'd1;
         end
      end
   end

   task automatic load_data_file();
      int fd;
      int n;
      string line;
      string tag;
      string name;
      logic [31:0] a;
      logic [31:0] d;
      fd = $fopen("tests/program_input.txt", "r");
      if (fd == 0) begin
         $display("could not open tests/program_input.txt");
         load_ok = 1'b0;
      end else begin
         while (!$feof(fd)) begin
            n = $fgets(line, fd);
            n = $sscanf(line, "%s", tag);
            if (n < 1) begin
               continue;
            end
            if (tag == "I") begin
               n = $sscanf(line, "%s %h", tag, d);
               rom[prog_words] = d;
               prog_words++;
            end else if (tag == "D") begin
               n = $sscanf(line, "%s %h %h", tag, a, d);
               dmem[a[7:0]] = d;
            end else if (tag == "W") begin
               n = $sscanf(line, "%s %h %h %s", tag, a, d, name);
               wb_checker_i.add_write(a[DATA_ADDR_W-1:0], d, name);
               exp_writes++;
            end else if (tag == "L") begin
               n = $sscanf(line, "%s %h", tag, d);
               wb_checker_i.set_led(d[7:0]);
            end
         end
         $fclose(fd);
      end
   endtask

   initial begin
      clk = 1'b0;
      rst_n = 1'b0;
      wb_ack = 1'b0;
      wb_dat_r = '0;
      lfsr = 16'd11;
      busy = 1'b0;
      wait_left = 2'd0;
      prog_words = 0;
      exp_writes = 0;
      cycles = 0;
      load_ok = 1'b1;
      for (int i = 0; i < 1024; i++) begin
         rom[i] = 32'h0;
      end
      // pattern tied to every address bit
      for (int i = 0; i < 256; i++) begin
         dmem[i] = {8'ha5, i[7:0], ~i[7:0], i[7:0]};
      end
      load_data_file();
      limit = load_ok ? 20 * prog_words + 4 * exp_writes : 0;

      repeat (5) @(negedge clk);
      rst_n = 1'b1;

      while (!chk_done && cycles < limit) begin
         @(negedge clk);
         cycles++;
      end

      if (load_ok && chk_done && chk_errors == 0) begin
         $display("Done: no errors");
      end else begin
         if (load_ok && !chk_done) begin
            $display("timeout after %0d cycles, expected writes did not all appear", limit);
         end
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// File: tests/wb_checker.sv
// Wishbone write and LED checker
module wb_checker #(
   parameter int ADR_W = 16
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             cyc_i,
   input  logic             stb_i,
   input  logic             we_i,
   input  logic             ack_i,
   input  logic [ADR_W-1:0] adr_i,
   input  logic [31:0]      dat_i,
   input  logic [7:0]       led_i,
   output logic             done_o,
   output int               errors_o
);

   logic [ADR_W-1:0] exp_adr [$];
   logic [31:0] exp_dat [$];
   string exp_name [$];
   logic [7:0] exp_led;
   int seen;
   logic led_due;

   task automatic add_write(input logic [ADR_W-1:0] a, input logic [31:0] d, input string n);
      exp_adr.push_back(a);
      exp_dat.push_back(d);
      exp_name.push_back(n);
   endtask

   task automatic set_led(input logic [7:0] v);
      exp_led = v;
   endtask

   initial begin
      done_o = 1'b0;
      errors_o = 0;
      seen = 0;
      led_due = 1'b0;
   end

   always @(posedge clk) begin
      if (!rst_n) begin
         if (cyc_i) begin
            errors_o++;
            $display("bus cycle opened while reset is asserted");
         end
      end else if (led_due) begin
         // register 3 writeback lands no later than the last store
         if (led_i !== exp_led) begin
            errors_o++;
            $display("ERROR final_led: expected %h, actual %h", exp_led, led_i);
         end
         led_due = 1'b0;
         done_o = 1'b1;
         $display("checker: %0d writes seen, %0d errors", seen, errors_o);
      end else if (cyc_i && stb_i && we_i && ack_i) begin
         if (seen >= exp_adr.size()) begin
            errors_o++;
            $display("write to address %h beyond the expected list", adr_i);
         end else begin
            if (adr_i !== exp_adr[seen]) begin
               errors_o++;
               $display("ERROR %s: expected address %h, actual %h",
                        exp_name[seen], exp_adr[seen], adr_i);
            end
            if (dat_i !== exp_dat[seen]) begin
               errors_o++;
               $display("ERROR %s: expected data %h, actual %h",
                        exp_name[seen], exp_dat[seen], dat_i);
            end
            seen++;
            if (seen == exp_adr.size() && !done_o) begin
               led_due = 1'b1;
            end
         end
      end
   end

endmodule

// File: source/mips_pipeline.sv
// Five-stage MIPS core
module mips_pipeline #(
   parameter int DATA_ADDR_W = 16,
   parameter int IMEM_ADDR_W = 10
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  mips_pkg::word_t        instr_i,
   output logic [IMEM_ADDR_W-1:0] imem_addr_o,
   output logic                   wb_cyc_o,
   output logic                   wb_stb_o,
   output logic                   wb_we_o,
   output logic [DATA_ADDR_W-1:0] wb_adr_o,
   output mips_pkg::word_t        wb_dat_o,
   input  logic                   wb_ack_i,
   input  mips_pkg::word_t        wb_dat_i,
   output logic [7:0]             led_o
);

   logic mem_stall;
   logic load_stall;
   logic branch_taken;
   mips_pkg::word_t branch_target;

   // IF/ID
   mips_pkg::word_t if_instr;
   mips_pkg::word_t if_pc4;

   // register file read side
   mips_pkg::reg_addr_t rs_addr;
   mips_pkg::reg_addr_t rt_addr;
   mips_pkg::word_t rd_data1;
   mips_pkg::word_t rd_data2;

   // ID/EX
   mips_pkg::word_t id_pc4;
   mips_pkg::word_t id_op1;
   mips_pkg::word_t id_op2;
   mips_pkg::word_t id_imm;
   mips_pkg::reg_addr_t id_rs;
   mips_pkg::reg_addr_t id_rt;
   mips_pkg::reg_addr_t id_rd;
   mips_pkg::funct_t id_funct;
   logic id_regwrite;
   logic id_memread;
   logic id_memwrite;
   logic id_memtoreg;
   logic id_alusrc;
   logic id_branch;

   // EX/MEM
   mips_pkg::word_t ex_result;
   mips_pkg::word_t ex_store_data;
   mips_pkg::reg_addr_t ex_rd;
   logic ex_regwrite;
   logic ex_memread;
   logic ex_memwrite;
   logic ex_memtoreg;

   // writeback
   logic wb_we;
   mips_pkg::reg_addr_t wb_rd;
   mips_pkg::word_t wb_data;

   fetch_stage #(
      .IMEM_ADDR_W(IMEM_ADDR_W)
   ) fetch_stage_i (
      .clk(clk), .rst_n(rst_n), .instr_i(instr_i),
      .mem_stall_i(mem_stall), .load_stall_i(load_stall),
      .branch_taken_i(branch_taken), .branch_target_i(branch_target),
      .imem_addr_o(imem_addr_o), .if_instr_o(if_instr), .if_pc4_o(if_pc4)
   );

   decode_stage decode_stage_i (
      .clk(clk), .rst_n(rst_n), .if_instr_i(if_instr), .if_pc4_i(if_pc4),
      .rd_data1_i(rd_data1), .rd_data2_i(rd_data2),
      .mem_stall_i(mem_stall), .branch_taken_i(branch_taken),
      .rs_addr_o(rs_addr), .rt_addr_o(rt_addr), .load_stall_o(load_stall),
      .id_pc4_o(id_pc4), .id_op1_o(id_op1), .id_op2_o(id_op2), .id_imm_o(id_imm),
      .id_rs_o(id_rs), .id_rt_o(id_rt), .id_rd_o(id_rd), .id_funct_o(id_funct),
      .id_regwrite_o(id_regwrite), .id_memread_o(id_memread),
      .id_memwrite_o(id_memwrite), .id_memtoreg_o(id_memtoreg),
      .id_alusrc_o(id_alusrc), .id_branch_o(id_branch)
   );

   reg_file reg_file_i (
      .clk(clk), .rst_n(rst_n), .rs_addr_i(rs_addr), .rt_addr_i(rt_addr),
      .wr_en_i(wb_we), .wr_addr_i(wb_rd), .wr_data_i(wb_data),
      .rd_data1_o(rd_data1), .rd_data2_o(rd_data2), .led_o(led_o)
   );

   execute_stage execute_stage_i (
      .clk(clk), .rst_n(rst_n),
      .id_pc4_i(id_pc4), .id_op1_i(id_op1), .id_op2_i(id_op2), .id_imm_i(id_imm),
      .id_rs_i(id_rs), .id_rt_i(id_rt), .id_rd_i(id_rd), .id_funct_i(id_funct),
      .id_regwrite_i(id_regwrite), .id_memread_i(id_memread),
      .id_memwrite_i(id_memwrite), .id_memtoreg_i(id_memtoreg),
      .id_alusrc_i(id_alusrc), .id_branch_i(id_branch),
      .mem_stall_i(mem_stall), .wb_we_i(wb_we), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
      .ex_result_o(ex_result), .ex_store_data_o(ex_store_data), .ex_rd_o(ex_rd),
      .ex_regwrite_o(ex_regwrite), .ex_memread_o(ex_memread),
      .ex_memwrite_o(ex_memwrite), .ex_memtoreg_o(ex_memtoreg),
      .branch_taken_o(branch_taken), .branch_target_o(branch_target)
   );

   mem_wb_stage #(
      .DATA_ADDR_W(DATA_ADDR_W)
   ) mem_wb_stage_i (
      .clk(clk), .rst_n(rst_n),
      .ex_result_i(ex_result), .ex_store_data_i(ex_store_data), .ex_rd_i(ex_rd),
      .ex_regwrite_i(ex_regwrite), .ex_memread_i(ex_memread),
      .ex_memwrite_i(ex_memwrite), .ex_memtoreg_i(ex_memtoreg),
      .wb_ack_i(wb_ack_i), .wb_dat_i(wb_dat_i),
      .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o),
      .wb_adr_o(wb_adr_o), .wb_dat_o(wb_dat_o), .mem_stall_o(mem_stall),
      .wb_reg_we_o(wb_we), .wb_reg_rd_o(wb_rd), .wb_reg_data_o(wb_data)
   );

endmodule

// File: source/mem_wb_stage.sv
// Data access, MEM/WB register and writeback
module mem_wb_stage #(
   parameter int DATA_ADDR_W = 16
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  mips_pkg::word_t        ex_result_i,
   input  mips_pkg::word_t        ex_store_data_i,
   input  mips_pkg::reg_addr_t    ex_rd_i,
   input  logic                   ex_regwrite_i,
   input  logic                   ex_memread_i,
   input  logic                   ex_memwrite_i,
   input  logic                   ex_memtoreg_i,
   input  logic                   wb_ack_i,
   input  mips_pkg::word_t        wb_dat_i,
   output logic                   wb_cyc_o,
   output logic                   wb_stb_o,
   output logic                   wb_we_o,
   output logic [DATA_ADDR_W-1:0] wb_adr_o,
   output mips_pkg::word_t        wb_dat_o,
   output logic                   mem_stall_o,
   output logic                   wb_reg_we_o,
   output mips_pkg::reg_addr_t    wb_reg_rd_o,
   output mips_pkg::word_t        wb_reg_data_o
);

   logic mem_req;
   logic ack_hit;
   logic pending;
   logic memtoreg_q;
   mips_pkg::word_t load_q;
   mips_pkg::word_t result_q;

   assign mem_req = ex_memread_i || ex_memwrite_i;
   // pending keeps cyc low for one cycle after ack
   assign wb_cyc_o = mem_req && !pending;
   assign wb_stb_o = wb_cyc_o;
   assign wb_we_o = wb_cyc_o && ex_memwrite_i;
   assign wb_adr_o = ex_result_i[DATA_ADDR_W+1:2];
   assign wb_dat_o = ex_store_data_i;

   assign ack_hit = wb_cyc_o && wb_ack_i;
   assign mem_stall_o = mem_req && !ack_hit;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pending <= 1'b0;
      end else begin
         pending <= ack_hit;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_reg_we_o <= 1'b0;
         memtoreg_q <= 1'b0;
      end else if (!mem_stall_o) begin
         wb_reg_we_o <= ex_regwrite_i;
         memtoreg_q <= ex_memtoreg_i;
      end
   end

   // load data is valid on the ack cycle when this register loads
   always_ff @(posedge clk) begin
      if (!mem_stall_o) begin
         load_q <= wb_dat_i;
         result_q <= ex_result_i;
         wb_reg_rd_o <= ex_rd_i;
      end
   end

   assign wb_reg_data_o = memtoreg_q ? load_q : result_q;

   assert property (@(posedge clk) disable iff (!rst_n)
      (wb_stb_o && !wb_ack_i) |=>
         (wb_stb_o && $stable(wb_adr_o) && $stable(wb_we_o) && $stable(wb_dat_o)));

endmodule

// File: source/execute_stage.sv
// Execute stage and EX/MEM register
module execute_stage (
   input  logic                clk,
   input  logic                rst_n,
   input  mips_pkg::word_t     id_pc4_i,
   input  mips_pkg::word_t     id_op1_i,
   input  mips_pkg::word_t     id_op2_i,
   input  mips_pkg::word_t     id_imm_i,
   input  mips_pkg::reg_addr_t id_rs_i,
   input  mips_pkg::reg_addr_t id_rt_i,
   input  mips_pkg::reg_addr_t id_rd_i,
   input  mips_pkg::funct_t    id_funct_i,
   input  logic                id_regwrite_i,
   input  logic                id_memread_i,
   input  logic                id_memwrite_i,
   input  logic                id_memtoreg_i,
   input  logic                id_alusrc_i,
   input  logic                id_branch_i,
   input  logic                mem_stall_i,
   input  logic                wb_we_i,
   input  mips_pkg::reg_addr_t wb_rd_i,
   input  mips_pkg::word_t     wb_data_i,
   output mips_pkg::word_t     ex_result_o,
   output mips_pkg::word_t     ex_store_data_o,
   output mips_pkg::reg_addr_t ex_rd_o,
   output logic                ex_regwrite_o,
   output logic                ex_memread_o,
   output logic                ex_memwrite_o,
   output logic                ex_memtoreg_o,
   output logic                branch_taken_o,
   output mips_pkg::word_t     branch_target_o
);

   mips_pkg::word_t op_a;
   mips_pkg::word_t fwd_b;
   mips_pkg::word_t op_b;
   mips_pkg::word_t alu_result;
   mips_pkg::alu_op_t alu_op;

   // EX/MEM has priority over MEM/WB
   // a load in EX/MEM has no result yet
   function automatic mips_pkg::word_t fwd(input mips_pkg::reg_addr_t src,
                                          input mips_pkg::word_t reg_val);
      if (ex_regwrite_o && !ex_memtoreg_o && (ex_rd_o != '0) && (ex_rd_o == src)) begin
         return ex_result_o;
      end else if (wb_we_i && (wb_rd_i != '0) && (wb_rd_i == src)) begin
         return wb_data_i;
      end
      return reg_val;
   endfunction

   always_comb begin
      op_a = fwd(id_rs_i, id_op1_i);
      fwd_b = fwd(id_rt_i, id_op2_i);
   end

   assign op_b = id_alusrc_i ? id_imm_i : fwd_b;

   // immediate forms all add
   always_comb begin
      if (id_alusrc_i) begin
         alu_op = mips_pkg::ALU_ADD;
      end else begin
         case (id_funct_i)
            mips_pkg::FUNCT_SUB: alu_op = mips_pkg::ALU_SUB;
            mips_pkg::FUNCT_AND: alu_op = mips_pkg::ALU_AND;
            mips_pkg::FUNCT_OR:  alu_op = mips_pkg::ALU_OR;
            mips_pkg::FUNCT_SLT: alu_op = mips_pkg::ALU_SLT;
            default:             alu_op = mips_pkg::ALU_ADD;
         endcase
      end
   end

   always_comb begin
      case (alu_op)
         mips_pkg::ALU_SUB: alu_result = op_a - op_b;
         mips_pkg::ALU_AND: alu_result = op_a & op_b;
         mips_pkg::ALU_OR:  alu_result = op_a | op_b;
         mips_pkg::ALU_SLT: alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
         default:           alu_result = op_a + op_b;
      endcase
   end

   // beq resolves here but never while frozen
   assign branch_taken_o = id_branch_i && (op_a == fwd_b) && !mem_stall_i;
   assign branch_target_o = id_pc4_i + {id_imm_i[29:0], 2'b00};

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ex_regwrite_o <= 1'b0;
         ex_memread_o <= 1'b0;
         ex_memwrite_o <= 1'b0;
         ex_memtoreg_o <= 1'b0;
      end else if (!mem_stall_i) begin
         ex_regwrite_o <= id_regwrite_i;
         ex_memread_o <= id_memread_i;
         ex_memwrite_o <= id_memwrite_i;
         ex_memtoreg_o <= id_memtoreg_i;
      end
   end

   always_ff @(posedge clk) begin
      if (!mem_stall_i) begin
         ex_result_o <= alu_result;
         ex_store_data_o <= fwd_b;
         ex_rd_o <= id_rd_i;
      end
   end

   // the slot behind a taken beq is always flushed
   assert property (@(posedge clk) disable iff (!rst_n)
      branch_taken_o |=> !branch_taken_o);

endmodule

// File: source/reg_file.sv
// Register file with LED mirror
module reg_file (
   input  logic                clk,
   input  logic                rst_n,
   input  mips_pkg::reg_addr_t rs_addr_i,
   input  mips_pkg::reg_addr_t rt_addr_i,
   input  logic                wr_en_i,
   input  mips_pkg::reg_addr_t wr_addr_i,
   input  mips_pkg::word_t     wr_data_i,
   output mips_pkg::word_t     rd_data1_o,
   output mips_pkg::word_t     rd_data2_o,
   output logic [7:0]          led_o
);

   mips_pkg::word_t regs [32];

   // r0 is hardwired, a write in flight is seen at once
   function automatic mips_pkg::word_t read_port(input mips_pkg::reg_addr_t addr);
      if (addr == '0) begin
         return '0;
      end else if (wr_en_i && (wr_addr_i == addr)) begin
         return wr_data_i;
      end
      return regs[addr];
   endfunction

   always_comb begin
      rd_data1_o = read_port(rs_addr_i);
      rd_data2_o = read_port(rt_addr_i);
   end

   always_ff @(posedge clk) begin
      if (wr_en_i && (wr_addr_i != '0)) begin
         regs[wr_addr_i] <= wr_data_i;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         led_o <= '0;
      end else if (wr_en_i && (wr_addr_i == mips_pkg::LED_REG)) begin
         led_o <= wr_data_i[7:0];
      end
   end

endmodule

// File: source/decode_stage.sv
// Decode stage and ID/EX register
module decode_stage (
   input  logic                clk,
   input  logic                rst_n,
   input  mips_pkg::word_t     if_instr_i,
   input  mips_pkg::word_t     if_pc4_i,
   input  mips_pkg::word_t     rd_data1_i,
   input  mips_pkg::word_t     rd_data2_i,
   input  logic                mem_stall_i,
   input  logic                branch_taken_i,
   output mips_pkg::reg_addr_t rs_addr_o,
   output mips_pkg::reg_addr_t rt_addr_o,
   output logic                load_stall_o,
   output mips_pkg::word_t     id_pc4_o,
   output mips_pkg::word_t     id_op1_o,
   output mips_pkg::word_t     id_op2_o,
   output mips_pkg::word_t     id_imm_o,
   output mips_pkg::reg_addr_t id_rs_o,
   output mips_pkg::reg_addr_t id_rt_o,
   output mips_pkg::reg_addr_t id_rd_o,
   output mips_pkg::funct_t    id_funct_o,
   output logic                id_regwrite_o,
   output logic                id_memread_o,
   output logic                id_memwrite_o,
   output logic                id_memtoreg_o,
   output logic                id_alusrc_o,
   output logic                id_branch_o
);

   mips_pkg::opcode_t opcode;
   mips_pkg::reg_addr_t dest;
   mips_pkg::word_t imm;
   logic regdst;
   // regwrite, memread, memwrite, memtoreg, alusrc, branch
   logic [5:0] ctrl;
   logic [5:0] ctrl_q;

   assign opcode = if_instr_i[31:26];
   assign rs_addr_o = if_instr_i[25:21];
   assign rt_addr_o = if_instr_i[20:16];
   assign imm = {{16{if_instr_i[15]}}, if_instr_i[15:0]};
   assign dest = regdst ? if_instr_i[15:11] : rt_addr_o;

   always_comb begin
      regdst = 1'b0;
      ctrl = 6'b000000;
      case (opcode)
         mips_pkg::OP_RTYPE: begin
            regdst = 1'b1;
            ctrl = 6'b100000;
         end
         mips_pkg::OP_ADDI: ctrl = 6'b100010;
         mips_pkg::OP_LW:   ctrl = 6'b110110;
         mips_pkg::OP_SW:   ctrl = 6'b001010;
         mips_pkg::OP_BEQ:  ctrl = 6'b000001;
         default:           ctrl = 6'b000000;
      endcase
   end

   // load in EX feeding the instruction in ID
   assign load_stall_o = id_memread_o && !mem_stall_i &&
                         ((id_rd_o == rs_addr_o) || (id_rd_o == rt_addr_o));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ctrl_q <= '0;
      end else if (!mem_stall_i) begin
         if (load_stall_o || branch_taken_i) begin
            ctrl_q <= '0;
         end else begin
            ctrl_q <= ctrl;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!mem_stall_i) begin
         id_pc4_o <= if_pc4_i;
         id_op1_o <= rd_data1_i;
         id_op2_o <= rd_data2_i;
         id_imm_o <= imm;
         id_rs_o <= rs_addr_o;
         id_rt_o <= rt_addr_o;
         id_rd_o <= dest;
         id_funct_o <= if_instr_i[5:0];
      end
   end

   assign {id_regwrite_o, id_memread_o, id_memwrite_o,
           id_memtoreg_o, id_alusrc_o, id_branch_o} = ctrl_q;

endmodule

// File: source/fetch_stage.sv
// Instruction fetch stage
module fetch_stage #(
   parameter int IMEM_ADDR_W = 10
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  mips_pkg::word_t        instr_i,
   input  logic                   mem_stall_i,
   input  logic                   load_stall_i,
   input  logic                   branch_taken_i,
   input  mips_pkg::word_t        branch_target_i,
   output logic [IMEM_ADDR_W-1:0] imem_addr_o,
   output mips_pkg::word_t        if_instr_o,
   output mips_pkg::word_t        if_pc4_o
);

   mips_pkg::word_t pc;
   mips_pkg::word_t pc4;

   assign pc4 = pc + 32'd4;
   // word address into the rom
   assign imem_addr_o = pc[IMEM_ADDR_W+1:2];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc <= '0;
      end else if (mem_stall_i) begin
         pc <= pc;
      end else if (branch_taken_i) begin
         pc <= branch_target_i;
      end else if (!load_stall_i) begin
         pc <= pc4;
      end
   end

   // IF/ID, squashed on a taken branch
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         if_instr_o <= mips_pkg::NOP_WORD;
      end else if (!mem_stall_i) begin
         if (branch_taken_i) begin
            if_instr_o <= mips_pkg::NOP_WORD;
         end else if (!load_stall_i) begin
            if_instr_o <= instr_i;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!mem_stall_i && !load_stall_i) begin
         if_pc4_o <= pc4;
      end
   end

endmodule

// File: source/mips_pkg.sv
// MIPS core shared definitions
package mips_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_addr_t;
   typedef logic [5:0]  opcode_t;
   typedef logic [5:0]  funct_t;
   typedef logic [3:0]  alu_op_t;

   // primary opcodes
   localparam opcode_t OP_RTYPE = 6'h00;
   localparam opcode_t OP_ADDI  = 6'h08;
   localparam opcode_t OP_LW    = 6'h23;
   localparam opcode_t OP_SW    = 6'h2b;
   localparam opcode_t OP_BEQ   = 6'h04;

   // r-type function field
   localparam funct_t FUNCT_ADD = 6'h20;
   localparam funct_t FUNCT_SUB = 6'h22;
   localparam funct_t FUNCT_AND = 6'h24;
   localparam funct_t FUNCT_OR  = 6'h25;
   localparam funct_t FUNCT_SLT = 6'h2a;

   // alu selector, textbook encoding
   localparam alu_op_t ALU_AND = 4'b0000;
   localparam alu_op_t ALU_OR  = 4'b0001;
   localparam alu_op_t ALU_ADD = 4'b0010;
   localparam alu_op_t ALU_SUB = 4'b0110;
   localparam alu_op_t ALU_SLT = 4'b0111;

   // register shown on the leds
   localparam reg_addr_t LED_REG = 5'd3;

   // sll r0,r0,0 used as a bubble
   localparam word_t NOP_WORD = 32'h0000_0000;

endpackage
